// ==== list.f ====
source/cpu_pkg.sv
source/alu.sv
source/pointer_pair.sv
source/datapath.sv
source/control_unit.sv
source/cpu.sv
testbench/tb_clock.sv
testbench/cpu_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps
module alu (
    input  logic [7:0]        a,
    input  logic [7:0]        b,
    input  cpu_pkg::alu_op_t  op,
    input  logic              carry_in,
    output logic [7:0]        result,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    logic [data_w:0] wide;
    logic            cin;
    logic            carry_out;
    logic            overflow;

    // Only the chained forms consume the stored carry.
    assign cin = (op == adc || op == sbc) ? carry_in : 1'b0;

    always_comb begin
        wide      = '0;
        carry_out = 1'b0;
        overflow  = 1'b0;
        case (op)
            add, adc: begin
                wide      = {1'b0, a} + {1'b0, b} + {{data_w{1'b0}}, cin};
                carry_out = wide[data_w];
                overflow  = (a[data_w-1] == b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
            end
            sub, sbc: begin
                // Carry reports a borrow here.
                wide      = {1'b0, a} - {1'b0, b} - {{data_w{1'b0}}, cin};
                carry_out = wide[data_w];
                overflow  = (a[data_w-1] != b[data_w-1]) && (wide[data_w-1] != a[data_w-1]);
            end
            and_op: wide = {1'b0, a & b};
            or_op:  wide = {1'b0, a | b};
            xor_op: wide = {1'b0, a ^ b};
            default: begin
                // Pass and the unused codes move the second operand.
                wide = {1'b0, b};
            end
        endcase
    end

    assign result  = wide[data_w-1:0];
    assign flags.z = (result == '0);
    assign flags.n = result[data_w-1];
    assign flags.c = carry_out;
    assign flags.v = overflow;

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/10ps
module control_unit (
    input  logic             n_clk,
    input  logic             n_rst,
    input  logic [7:0]       ir,
    input  cpu_pkg::flags_t  flags,
    output cpu_pkg::ctrl_t   ctrl,
    output logic             halted
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        fetch = 2'd0,
        exec1 = 2'd1,
        exec2 = 2'd2,
        halt  = 2'd3
    } state_t;

    state_t  state;
    state_t  state_next;
    opcode_t opcode;
    logic    is_halt;
    logic    is_alu;

    assign opcode  = opcode_t'(ir[6:4]);
    assign is_halt = (ir == halt_instr);
    assign is_alu  = ir[7];

    // Halt shows from the first execute cycle on.
    assign halted = (state == halt) || (state == exec1 && is_halt);

    // ##################################################
    // Sequencer.
    // ##################################################

    // Reset parks in exec2 with a cleared IR, an idle cycle before fetch.
    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= exec2;
        end else begin
            state <= state_next;
        end
    end

    // ##################################################
    // Control word per step.
    // ##################################################

    always_comb begin
        ctrl       = ctrl_idle;
        state_next = fetch;
        case (state)
            fetch: begin
                ctrl.mem_rd  = 1'b1;
                ctrl.ip_inc  = 1'b1;
                ctrl.ir_we   = 1'b1;
                ctrl.bus_src = src_mem;
                state_next   = exec1;
            end
            exec1: begin
                if (is_halt) begin
                    state_next = halt;
                end else if (is_alu) begin
                    ctrl.a_we       = 1'b1;
                    ctrl.flags_we   = 1'b1;
                    ctrl.bus_src    = src_alu;
                    ctrl.alu_zero_b = ir[2];
                end else begin
                    case (opcode)
                        lda_imm, ldb_imm: begin
                            ctrl.mem_rd  = 1'b1;
                            ctrl.ip_inc  = 1'b1;
                            ctrl.bus_src = src_mem;
                            ctrl.a_we    = (opcode == lda_imm);
                            ctrl.b_we    = (opcode == ldb_imm);
                        end
                        lda_mem: begin
                            ctrl.mem_rd  = 1'b1;
                            ctrl.addr_dp = 1'b1;
                            ctrl.bus_src = src_mem;
                            ctrl.a_we    = 1'b1;
                        end
                        sta_mem: begin
                            ctrl.mem_wr  = 1'b1;
                            ctrl.addr_dp = 1'b1;
                        end
                        ldp_imm: begin
                            ctrl.mem_rd = 1'b1;
                            ctrl.ip_inc = 1'b1;
                            ctrl.pl_we  = 1'b1;
                            state_next  = exec2;
                        end
                        swp:     ctrl.swap = 1'b1;
                        swz:     ctrl.swap = flags.z;
                        default: ctrl = ctrl_idle;
                    endcase
                end
            end
            exec2: begin
                // High pointer byte. Any other IR idles here.
                if (!is_alu && opcode == ldp_imm) begin
                    ctrl.mem_rd = 1'b1;
                    ctrl.ip_inc = 1'b1;
                    ctrl.ph_we  = 1'b1;
                end
            end
            default: state_next = halt;
        endcase
    end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/10ps
module cpu (
    input  logic               n_clk,
    input  logic               n_rst,
    input  logic [7:0]         mem_rdata,
    output cpu_pkg::mem_req_t  mem_req,
    output logic               halted
);
    import cpu_pkg::*;

    ctrl_t             ctrl;
    flags_t            flags;
    flags_t            alu_flags;
    alu_op_t           alu_op;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] a;
    logic [data_w-1:0] alu_b;
    logic [data_w-1:0] alu_result;
    logic              carry;
    logic [addr_w-1:0] addr;

    control_unit u_ctrl (
        .n_clk(n_clk), .n_rst(n_rst), .ir(ir), .flags(flags),
        .ctrl(ctrl), .halted(halted)
    );

    datapath u_dp (
        .n_clk(n_clk), .n_rst(n_rst), .ctrl(ctrl), .mem_rdata(mem_rdata),
        .alu_result(alu_result), .alu_flags(alu_flags), .ir(ir), .a(a),
        .alu_b(alu_b), .alu_op(alu_op), .carry(carry), .flags(flags)
    );

    pointer_pair u_ptr (
        .n_clk(n_clk), .n_rst(n_rst), .ctrl(ctrl), .mem_rdata(mem_rdata), .addr(addr)
    );

    alu u_alu (
        .a(a), .b(alu_b), .op(alu_op), .carry_in(carry),
        .result(alu_result), .flags(alu_flags)
    );

    // Strobes are active low on the pins.
    assign mem_req.addr  = addr;
    assign mem_req.wdata = a;
    assign mem_req.n_oe  = ~ctrl.mem_rd;
    assign mem_req.n_we  = ~ctrl.mem_wr;

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    // ##################################################
    // Widths and fixed encodings.
    // ##################################################

    localparam int data_w = 8;
    localparam int addr_w = 16;

    // The all-zero byte stops the sequencer.
    localparam logic [data_w-1:0] halt_instr = 8'h00;

    // Instruction class from ir[6:4] when ir[7] is clear.
    typedef enum logic [2:0] {
        nop     = 3'd0,
        lda_imm = 3'd1,
        ldb_imm = 3'd2,
        lda_mem = 3'd3,
        sta_mem = 3'd4,
        ldp_imm = 3'd5,
        swp     = 3'd6,
        swz     = 3'd7
    } opcode_t;

    // ALU operation from ir[6:3] when ir[7] is set.
    typedef enum logic [3:0] {
        add    = 4'd0,
        adc    = 4'd1,
        sub    = 4'd2,
        sbc    = 4'd3,
        and_op = 4'd4,
        or_op  = 4'd5,
        xor_op = 4'd6,
        pass   = 4'd7
    } alu_op_t;

    // Carry sits in bit 1.
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

    typedef enum logic [1:0] {
        src_none = 2'd0,
        src_mem  = 2'd1,
        src_alu  = 2'd2
    } bus_src_t;

    // ##################################################
    // Control word and memory port.
    // ##################################################

    typedef struct packed {
        logic     mem_rd;
        logic     mem_wr;
        logic     addr_dp;
        logic     ip_inc;
        logic     ir_we;
        logic     a_we;
        logic     b_we;
        logic     flags_we;
        logic     pl_we;
        logic     ph_we;
        logic     swap;
        bus_src_t bus_src;
        logic     alu_zero_b;
    } ctrl_t;

    localparam ctrl_t ctrl_idle = ctrl_t'(0);

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              n_oe;
        logic              n_we;
    } mem_req_t;

endpackage

// ==== source/datapath.sv ====
`timescale 1ns/10ps
module datapath (
    input  logic              n_clk,
    input  logic              n_rst,
    input  cpu_pkg::ctrl_t    ctrl,
    input  logic [7:0]        mem_rdata,
    input  logic [7:0]        alu_result,
    input  cpu_pkg::flags_t   alu_flags,
    output logic [7:0]        ir,
    output logic [7:0]        a,
    output logic [7:0]        alu_b,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              carry,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    logic [data_w-1:0] bus;
    logic [data_w-1:0] b_reg;

    // ##################################################
    // Internal bus.
    // ##################################################

    always_comb begin
        case (ctrl.bus_src)
            src_mem: bus = mem_rdata;
            src_alu: bus = alu_result;
            default: bus = '0;
        endcase
    end

    // ##################################################
    // Registers.
    // ##################################################

    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            ir    <= '0;
            a     <= '0;
            b_reg <= '0;
            flags <= '0;
        end else begin
            if (ctrl.ir_we) begin
                ir <= bus;
            end
            if (ctrl.a_we) begin
                a <= bus;
            end
            if (ctrl.b_we) begin
                b_reg <= bus;
            end
            if (ctrl.flags_we) begin
                flags <= alu_flags;
            end
        end
    end

    // ##################################################
    // ALU operands.
    // ##################################################

    assign alu_b  = ctrl.alu_zero_b ? '0 : b_reg;
    // Operation field goes to the ALU undecoded.
    assign alu_op = alu_op_t'(ir[6:3]);
    assign carry  = flags.c;

endmodule

// ==== source/pointer_pair.sv ====
`timescale 1ns/10ps
module pointer_pair (
    input  logic            n_clk,
    input  logic            n_rst,
    input  cpu_pkg::ctrl_t  ctrl,
    input  logic [7:0]      mem_rdata,
    output logic [15:0]     addr
);
    import cpu_pkg::*;

    logic [addr_w-1:0] p0;
    logic [addr_w-1:0] p1;
    logic              sel;
    logic [addr_w-1:0] ip;
    logic [addr_w-1:0] dp;
    logic [addr_w-1:0] ip_next;
    logic [addr_w-1:0] dp_next;

    // Sel set means p1 is the instruction pointer.
    assign ip   = sel ? p1 : p0;
    assign dp   = sel ? p0 : p1;
    assign addr = ctrl.addr_dp ? dp : ip;

    always_comb begin
        ip_next = ip;
        dp_next = dp;
        if (ctrl.ip_inc) begin
            ip_next = ip + 1'b1;
        end
        if (ctrl.pl_we) begin
            dp_next[data_w-1:0] = mem_rdata;
        end
        if (ctrl.ph_we) begin
            dp_next[addr_w-1:data_w] = mem_rdata;
        end
    end

    // Swapping roles is the jump.
    always_ff @(posedge n_clk or negedge n_rst) begin
        if (!n_rst) begin
            p0  <= '0;
            p1  <= '0;
            sel <= 1'b0;
        end else begin
            if (sel) begin
                p1 <= ip_next;
                p0 <= dp_next;
            end else begin
                p0 <= ip_next;
                p1 <= dp_next;
            end
            if (ctrl.swap) begin
                sel <= ~sel;
            end
        end
    end

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/10ps
module cpu_tb;
    import cpu_pkg::*;

    localparam int budget_short = 200;
    localparam int budget_long  = 400;
    localparam int watchdog_ns  = ((4 * budget_short + budget_long) * 3 + 5 * 20) * 10;

    logic        n_clk;
    logic        n_rst;
    logic [7:0]  mem_rdata;
    mem_req_t    mem_req;
    logic        halted;
    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [24:0] exp_q [$];
    logic [31:0] seed = 32'hd2df69c9;
    logic [15:0] wp;
    logic [15:0] m_ip;
    logic [15:0] m_dp;
    logic [7:0]  m_a;
    logic [7:0]  m_b;
    logic        m_z;
    logic        m_c;
    logic        m_halt;
    int          err_count = 0;
    int          check_count = 0;

    tb_clock u_clk (.n_clk(n_clk), .n_rst(n_rst));

    cpu u_dut (
        .n_clk(n_clk), .n_rst(n_rst), .mem_rdata(mem_rdata), .mem_req(mem_req), .halted(halted)
    );

    // ##################################################
    // Memory model.
    // ##################################################

    assign mem_rdata = mem_req.n_oe ? 8'h00 : mem[mem_req.addr];

    always @(posedge n_clk) begin
        if (!mem_req.n_we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand8();
        seed = xorshift(seed);
        return seed[7:0];
    endfunction

    task automatic emit(input int n, input logic [31:0] bytes);
        for (int k = n - 1; k >= 0; k--) begin
            mem[wp] = bytes[k*8 +: 8];
            wp = wp + 1'b1;
        end
    endtask

    task automatic build_program(input int kind);
        logic [15:0] next;
        logic [7:0]  v;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ (i[15:8] * 8'd7) ^ 8'h3c;
        end
        wp = 16'h0000;
        case (kind)
            1: begin
                emit(3, {8'h50, 8'h00, 8'h90});
                emit(3, {8'h10, rand8(), 8'h40});
            end
            2: begin
                emit(3, {8'h50, rand8(), 8'h80 | (rand8() & 8'h0f)});
                repeat (60) begin
                    v = rand8();
                    case (v[1:0])
                        2'd0: emit(2, {8'h10, rand8()});
                        2'd1: emit(2, {8'h20, rand8()});
                        2'd2: emit(1, 8'h30);
                        default: emit(1, 8'h40);
                    endcase
                end
            end
            3: begin
                emit(3, {8'h50, rand8(), 8'ha0});
                for (int s = 0; s < 40; s++) begin
                    v = rand8();
                    if (s % 8 == 0) emit(2, {8'h10, rand8()});
                    // Zero as the B source about one time in four.
                    emit(4, {8'h20, rand8(), {2'b10, v[2:0], v[5:4] == 2'b00, 2'b00}, 8'h40});
                end
            end
            4: begin
                for (int k = 1; k <= 6; k++) begin
                    v = rand8();
                    next = {k[3:0], 4'h0, v[7:4], 4'h0};
                    emit(3, {8'h50, next[7:0], next[15:8]});
                    emit(4, {8'h10, k[0] ? 8'h00 : (rand8() | 8'h01), 8'hac, 8'h70});
                    emit(1, 8'h60);
                    wp = next;
                end
            end
            default: begin
                for (int i = 0; i < 512; i++) mem[i] = rand8();
            end
        endcase
        if (kind != 5) emit(1, 8'h00);
    endtask

    // ##################################################
    // Instruction-level reference model.
    // ##################################################

    function automatic logic [7:0] read_ip();
        logic [7:0] b;
        b = ref_mem[m_ip];
        exp_q.push_back({1'b0, m_ip, 8'h00});
        m_ip = m_ip + 1'b1;
        return b;
    endfunction

    task automatic alu_model(input logic [7:0] ir);
        int x;
        int y;
        int cin;
        int r;
        x   = m_a;
        y   = ir[2] ? 0 : m_b;
        cin = (ir[6:3] == 4'd1 || ir[6:3] == 4'd3) ? m_c : 0;
        case (ir[6:3])
            4'd0, 4'd1: r = x + y + cin;
            4'd2, 4'd3: r = x - y - cin;
            4'd4: r = x & y;
            4'd5: r = x | y;
            4'd6: r = x ^ y;
            default: r = y;
        endcase
        // Carry out on add, borrow on subtract.
        m_c = (ir[6:3] < 4'd2) ? (r > 255) : (ir[6:3] < 4'd4) ? (r < 0) : 1'b0;
        m_a = r[7:0];
        m_z = (m_a == 8'h00);
    endtask

    task automatic model_run(input int budget);
        logic [7:0] ir;
        int         count;
        count  = 0;
        m_ip   = '0;
        m_dp   = '0;
        m_a    = '0;
        m_b    = '0;
        {m_z, m_c} = '0;
        m_halt = 1'b0;
        exp_q.delete();
        for (int i = 0; i < 65536; i++) ref_mem[i] = mem[i];
        while (count < budget && !m_halt) begin
            ir = read_ip();
            count++;
            if (ir == 8'h00) begin
                m_halt = 1'b1;
            end else if (ir[7]) begin
                alu_model(ir);
            end else begin
                case (ir[6:4])
                    3'd1: m_a = read_ip();
                    3'd2: m_b = read_ip();
                    3'd3: begin
                        exp_q.push_back({1'b0, m_dp, 8'h00});
                        m_a = ref_mem[m_dp];
                    end
                    3'd4: begin
                        exp_q.push_back({1'b1, m_dp, m_a});
                        ref_mem[m_dp] = m_a;
                    end
                    3'd5: begin
                        m_dp[7:0]  = read_ip();
                        m_dp[15:8] = read_ip();
                    end
                    3'd6: {m_ip, m_dp} = {m_dp, m_ip};
                    3'd7: if (m_z) {m_ip, m_dp} = {m_dp, m_ip};
                    default: ;
                endcase
            end
        end
    endtask

    // ##################################################
    // Bus checker and tests.
    // ##################################################

    task automatic report_mismatch(input string sig, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("ERR %0t %s got %h exp %h", $time, sig, got, exp);
        err_count++;
    endtask

    task automatic watch_reset();
        repeat (4) begin
            @(negedge n_clk);
            check_count++;
            if (mem_req.n_oe !== 1'b1) report_mismatch("mem_req.n_oe", mem_req.n_oe, 1);
            if (mem_req.n_we !== 1'b1) report_mismatch("mem_req.n_we", mem_req.n_we, 1);
            if (halted !== 1'b0) report_mismatch("halted", halted, 0);
        end
    endtask

    task automatic check_run(input string name);
        logic [24:0] e;
        int          idle;
        int          errs;
        errs = err_count;
        idle = 0;
        while (exp_q.size() > 0 && idle < 8) begin
            @(negedge n_clk);
            if (!mem_req.n_oe && !mem_req.n_we) begin
                $display("Read and write strobes both low at %0t", $time);
                err_count++;
            end
            if (mem_req.n_oe && mem_req.n_we) begin
                idle++;
            end else begin
                idle = 0;
                e = exp_q.pop_front();
                check_count++;
                if (mem_req.n_we !== !e[24]) report_mismatch("mem_req.n_we", mem_req.n_we, !e[24]);
                if (mem_req.addr !== e[23:8]) report_mismatch("mem_req.addr", mem_req.addr, e[23:8]);
                if (e[24] && mem_req.wdata !== e[7:0]) begin
                    report_mismatch("mem_req.wdata", mem_req.wdata, e[7:0]);
                end
            end
        end
        if (idle >= 8) begin
            $display("Bus went idle in test %s with %0d accesses still expected", name, exp_q.size());
            err_count++;
        end else if (m_halt) begin
            repeat (4) begin
                @(negedge n_clk);
                check_count++;
                if (halted !== 1'b1) report_mismatch("halted", halted, 1);
                if (mem_req.n_oe !== 1'b1) report_mismatch("mem_req.n_oe", mem_req.n_oe, 1);
                if (mem_req.n_we !== 1'b1) report_mismatch("mem_req.n_we", mem_req.n_we, 1);
            end
        end
        $display("test %s done: %0d errors", name, err_count - errs);
    endtask

    task automatic run_test(input int kind, input string name, input int budget);
        @(posedge n_clk);
        #1;
        build_program(kind);
        model_run(budget);
        if (kind == 1) begin
            fork
                u_clk.apply_reset();
                watch_reset();
            join
        end else begin
            u_clk.apply_reset();
        end
        check_run(name);
    endtask

    initial begin
        run_test(1, "reset", budget_short);
        run_test(2, "moves", budget_short);
        run_test(3, "alu", budget_short);
        run_test(4, "swap", budget_short);
        run_test(5, "random", budget_long);
        $display("5 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps
module tb_clock (
    output logic n_clk,
    output logic n_rst
);
    initial begin
        n_clk = 1'b0;
        n_rst = 1'b0;
    end

    always #5 n_clk = ~n_clk;

    // Five cycles of reset, released just after a rising edge.
    task automatic apply_reset();
        n_rst = 1'b0;
        repeat (5) @(posedge n_clk);
        #1;
        n_rst = 1'b1;
    endtask

endmodule
